// File: vlog.f
source/conv_pkg.sv
source/window_if.sv
source/row_sequencer.sv
source/line_bank_set.sv
source/bank_router.sv
source/window_filter.sv
source/conv_row_engine.sv
tests/tb_conv_row_engine.sv

// File: tests/conv_stim.txt
// One 96-bit hex word per line, first 20 input row words (upper 32 bits zero, pixel 0 in the
// low byte), then 12 expected output words (eight 12-bit sums, sum 0 in the low bits)
// Pixel value is 32*row + column + 1
// Row 0
000000000807060504030201
000000000100f0e0d0c0b0a09
000000001817161514131211
00000000201f1e1d1c1b1a19
// Row 1
000000002827262524232221
00000000302f2e2d2c2b2a29
000000003837363534333231
00000000403f3e3d3c3b3a39
// Row 2
000000004847464544434241
00000000504f4e4d4c4b4a49
000000005857565554535251
00000000605f5e5d5c5b5a59
// Row 3
000000006867666564636261
00000000706f6e6d6c6b6a69
000000007877767574737271
00000000807f7e7d7c7b7a79
// Row 4
000000008887868584838281
00000000908f8e8d8c8b8a89
000000009897969594939291
00000000a09f9e9d9c9b9a99
// Sums for row 2
15f15614d14413b1320c9063
1a719e19518c18317a171168
1ef1e61dd1d41cb1c21b91b0
23722e22521c21320a2011f8
// Sums for row 3
27f27626d26425b2521890c3
2c72be2b52ac2a329a291288
30f3062fd2f42eb2e22d92d0
35734e34533c33332a321318
// Sums for row 4
39f39638d38437b372249123
3e73de3d53cc3c33ba3b13a8
42f42641d41440b4023f93f0
47746e46545c45344a441438

// File: tests/tb_conv_row_engine.sv
module tb_conv_row_engine;
    import conv_pkg::*;

    localparam int NUM_IN      = 20;
    localparam int NUM_OUT     = 12;
    localparam int RESET_CYC   = 8;
    localparam int CYCLE_LIMIT = 4 * (NUM_IN + NUM_OUT) + RESET_CYC;

    logic              clk;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    logic [WORD_W-1:0] in_data;
    logic              out_valid;
    logic              out_ready;
    logic [OUT_W-1:0]  out_data;

    logic [OUT_W-1:0]  stim_mem [NUM_IN + NUM_OUT];
    logic [OUT_W-1:0]  got_q [$];
    logic [31:0]       lfsr_state;
    logic              in_fire;
    logic              out_fire;
    logic              was_held;
    logic [OUT_W-1:0]  held_data;
    bit                monitor_on;
    int                accepted;
    int                cycle_cnt;
    int                run_start;
    int                errors;
    int                tests_run;
    int                tests_failed;
    int                test_err_start;

    conv_row_engine dut0 (
        .clk, .reset,
        .in_valid, .in_ready, .in_data,
        .out_valid, .out_ready, .out_data
    );

    always #20 clk = ~clk;

    // Galois LFSR stepped once per bit
    function automatic logic next_rand_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic int pixel_at(input int row, input int col);
        logic [OUT_W-1:0] w;
        w = stim_mem[row * WORDS_PER_ROW + col / ROW_PIXELS];
        return int'(w[(col % ROW_PIXELS) * PIXEL_W +: PIXEL_W]);
    endfunction

    // 3x3 box sum ending at (row, col) with zeros left of column 0
    function automatic logic [SUM_W-1:0] box_sum(input int row, input int col);
        int acc;
        acc = 0;
        for (int r = row - 2; r <= row; r++) begin
            for (int c = col - 2; c <= col; c++) begin
                if (c >= 0) begin
                    acc += pixel_at(r, c);
                end
            end
        end
        return SUM_W'(acc);
    endfunction

    ////////////////////
    // Timeout
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt - run_start > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////
    // Monitor samples half a cycle after the inputs settle
    always @(negedge clk) begin
        in_fire  = in_valid && in_ready;
        out_fire = out_valid && out_ready;
        if (monitor_on) begin
            if (was_held && out_valid !== 1'b1) begin
                $display("Fail at %0t: out_valid expected 1, got %b while stalled",
                         $time, out_valid);
                errors++;
            end else if (was_held && out_data !== held_data) begin
                $display("Fail at %0t: out_data expected %h, got %h while stalled",
                         $time, held_data, out_data);
                errors++;
            end
            if (out_valid === 1'b1 && got_q.size() == 0 &&
                accepted < 2 * WORDS_PER_ROW + 1) begin
                $display("Output appeared after only %0d input words", accepted);
                errors++;
            end
            if (in_fire) begin
                accepted++;
            end
            if (out_fire) begin
                if (got_q.size() >= NUM_OUT) begin
                    $display("Extra output word beyond the %0d expected", NUM_OUT);
                    errors++;
                end else if (out_data !== stim_mem[NUM_IN + got_q.size()]) begin
                    $display("Fail at %0t: out_data[%0d] expected %h, got %h", $time,
                             got_q.size(), stim_mem[NUM_IN + got_q.size()], out_data);
                    errors++;
                end
                got_q.push_back(out_data);
            end
            was_held  = out_valid && !out_ready;
            held_data = out_data;
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        #2;
        run_start = cycle_cnt;
        reset = 1'b1;
        repeat (RESET_CYC) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    task automatic run_stream(input bit gaps, input bit stalls);
        int sent;
        int quiet;
        sent = 0;
        quiet = 0;
        got_q.delete();
        accepted   = 0;
        was_held   = 1'b0;
        monitor_on = 1'b0;
        apply_reset();
        monitor_on = 1'b1;
        while (got_q.size() < NUM_OUT || quiet < 6) begin
            @(posedge clk);
            #2;
            if (in_fire) begin
                sent++;
            end
            // Valid holds until its word is taken
            if (!in_valid || in_fire) begin
                if (sent < NUM_IN && !(gaps && next_rand_bit())) begin
                    in_valid = 1'b1;
                    in_data  = stim_mem[sent][WORD_W-1:0];
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = stalls ? next_rand_bit() : 1'b1;
            if (got_q.size() >= NUM_OUT) begin
                quiet++;
            end
        end
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        monitor_on = 1'b0;
    endtask

    // Sums 0 and 1 are the ones that reach into the previous word
    task automatic check_edges();
        logic [OUT_W-1:0] word;
        logic [SUM_W-1:0] exp_sum;
        logic [SUM_W-1:0] got_sum;
        for (int k = 0; k < got_q.size(); k++) begin
            word = got_q[k];
            for (int j = 0; j < 2; j++) begin
                exp_sum = box_sum(2 + k / WORDS_PER_ROW, (k % WORDS_PER_ROW) * ROW_PIXELS + j);
                got_sum = word[j * SUM_W +: SUM_W];
                if (got_sum !== exp_sum) begin
                    $display("Fail at %0t: out_data[%0d] sum %0d expected %h, got %h",
                             $time, k, j, exp_sum, got_sum);
                    errors++;
                end
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_data        = '0;
        out_ready      = 1'b0;
        lfsr_state     = 32'hbb86;
        in_fire        = 1'b0;
        out_fire       = 1'b0;
        was_held       = 1'b0;
        held_data      = '0;
        monitor_on     = 1'b0;
        accepted       = 0;
        cycle_cnt      = 0;
        run_start      = 0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        $readmemh("tests/conv_stim.txt", stim_mem);

        apply_reset();
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("Fail at %0t: out_valid expected 0, got %b", $time, out_valid);
            errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("Fail at %0t: in_ready expected 1, got %b", $time, in_ready);
            errors++;
        end
        finish_test("reset state");

        run_stream(1'b0, 1'b0);
        finish_test("streaming without stalls");

        check_edges();
        finish_test("left edge and slab carry");

        run_stream(1'b0, 1'b1);
        finish_test("output stalls");

        run_stream(1'b1, 1'b0);
        if (got_q.size() != NUM_OUT) begin
            $display("Expected %0d output words, saw %0d", NUM_OUT, got_q.size());
            errors++;
        end
        finish_test("input gaps");

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: source/conv_row_engine.sv
module conv_row_engine (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [conv_pkg::WORD_W-1:0] in_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [conv_pkg::OUT_W-1:0]  out_data
);
    import conv_pkg::*;

    logic                  advance;
    logic                  wr_en;
    logic [BANK_IDX_W-1:0] wr_idx;
    logic [ADR_W-1:0]      wr_adr;
    logic [WORD_W-1:0]     wr_data;
    logic [ADR_W-1:0]      bank1_adr;
    logic [ADR_W-1:0]      bank2_adr;
    logic [ADR_W-1:0]      bank3_adr;
    logic [WORD_W-1:0]     bank1_data;
    logic [WORD_W-1:0]     bank2_data;
    logic [WORD_W-1:0]     bank3_data;
    logic [SLAB_W-1:0]     slab1;
    logic [SLAB_W-1:0]     slab2;
    logic [SLAB_W-1:0]     slab3;
    logic                  slab1_wr;
    logic                  slab2_wr;
    logic                  slab3_wr;
    logic [WORD_W-1:0]     row1_word;
    logic [WORD_W-1:0]     row2_word;
    logic [WORD_W-1:0]     row3_word;
    logic [SLAB_W-1:0]     row1_slab;
    logic [SLAB_W-1:0]     row2_slab;
    logic [SLAB_W-1:0]     row3_slab;
    logic                  row_valid;

    window_if win0 ();

    row_sequencer seq0 (
        .clk, .reset, .advance,
        .in_valid, .in_ready, .in_data,
        .win (win0.seq),
        .wr_en, .wr_idx, .wr_adr, .wr_data
    );

    line_bank_set banks0 (
        .clk, .reset, .advance,
        .wr_en, .wr_idx, .wr_adr, .wr_data,
        .bank1_adr, .bank2_adr, .bank3_adr,
        .slab1_wr, .slab2_wr, .slab3_wr,
        .bank1_data, .bank2_data, .bank3_data,
        .slab1, .slab2, .slab3
    );

    bank_router router0 (
        .clk, .reset, .advance,
        .win (win0.router),
        .bank1_adr, .bank2_adr, .bank3_adr,
        .bank1_data, .bank2_data, .bank3_data,
        .slab1, .slab2, .slab3,
        .slab1_wr, .slab2_wr, .slab3_wr,
        .row1_word, .row2_word, .row3_word,
        .row1_slab, .row2_slab, .row3_slab,
        .row_valid
    );

    window_filter filter0 (
        .clk, .reset,
        .row1_word, .row2_word, .row3_word,
        .row1_slab, .row2_slab, .row3_slab,
        .row_valid, .advance,
        .out_valid, .out_ready, .out_data
    );

endmodule

// File: source/window_filter.sv
module window_filter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [conv_pkg::WORD_W-1:0] row1_word,
    input  logic [conv_pkg::WORD_W-1:0] row2_word,
    input  logic [conv_pkg::WORD_W-1:0] row3_word,
    input  logic [conv_pkg::SLAB_W-1:0] row1_slab,
    input  logic [conv_pkg::SLAB_W-1:0] row2_slab,
    input  logic [conv_pkg::SLAB_W-1:0] row3_slab,
    input  logic                        row_valid,
    output logic                        advance,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [conv_pkg::OUT_W-1:0]  out_data
);
    import conv_pkg::*;

    row_word_u        w1;
    row_word_u        w2;
    row_word_u        w3;
    logic [SUM_W-1:0] col_sum [ROW_PIXELS+2];
    logic [OUT_W-1:0] sum_word;

    assign w1 = row1_word;
    assign w2 = row2_word;
    assign w3 = row3_word;

    // Pipeline moves unless the output is held
    assign advance = !out_valid || out_ready;

    ////////////////////
    // Column sums with slab pixels 6 and 7 first
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            col_sum[k] = SUM_W'(row1_slab[k*PIXEL_W +: PIXEL_W]) +
                         SUM_W'(row2_slab[k*PIXEL_W +: PIXEL_W]) +
                         SUM_W'(row3_slab[k*PIXEL_W +: PIXEL_W]);
        end
        for (int j = 0; j < ROW_PIXELS; j++) begin
            col_sum[j+2] = SUM_W'(w1.pix[j]) + SUM_W'(w2.pix[j]) + SUM_W'(w3.pix[j]);
        end
    end

    // Output j spans columns j-2 to j
    always_comb begin
        for (int j = 0; j < ROW_PIXELS; j++) begin
            sum_word[j*SUM_W +: SUM_W] = col_sum[j] + col_sum[j+1] + col_sum[j+2];
        end
    end

    ////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= row_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && row_valid) begin
            out_data <= sum_word;
        end
    end

    // Held word stays put until taken
    assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

// File: source/bank_router.sv
module bank_router (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        advance,
    window_if.router                    win,
    output logic [conv_pkg::ADR_W-1:0]  bank1_adr,
    output logic [conv_pkg::ADR_W-1:0]  bank2_adr,
    output logic [conv_pkg::ADR_W-1:0]  bank3_adr,
    input  logic [conv_pkg::WORD_W-1:0] bank1_data,
    input  logic [conv_pkg::WORD_W-1:0] bank2_data,
    input  logic [conv_pkg::WORD_W-1:0] bank3_data,
    input  logic [conv_pkg::SLAB_W-1:0] slab1,
    input  logic [conv_pkg::SLAB_W-1:0] slab2,
    input  logic [conv_pkg::SLAB_W-1:0] slab3,
    output logic                        slab1_wr,
    output logic                        slab2_wr,
    output logic                        slab3_wr,
    output logic [conv_pkg::WORD_W-1:0] row1_word,
    output logic [conv_pkg::WORD_W-1:0] row2_word,
    output logic [conv_pkg::WORD_W-1:0] row3_word,
    output logic [conv_pkg::SLAB_W-1:0] row1_slab,
    output logic [conv_pkg::SLAB_W-1:0] row2_slab,
    output logic [conv_pkg::SLAB_W-1:0] row3_slab,
    output logic                        row_valid
);
    import conv_pkg::*;

    logic [ADR_W-1:0]      role_adr [NUM_BANKS];
    logic [BANK_IDX_W-1:0] role_idx [NUM_BANKS];
    logic [BANK_IDX_W-1:0] idx_q [NUM_BANKS];
    logic [ADR_W-1:0]      bank_adr [NUM_BANKS];
    logic                  bank_use [NUM_BANKS];
    logic                  slab_wr_q [NUM_BANKS];
    logic [WORD_W-1:0]     bank_word [NUM_BANKS];
    logic [SLAB_W-1:0]     bank_slab [NUM_BANKS];
    logic [WORD_W-1:0]     row_word [NUM_BANKS];
    logic [SLAB_W-1:0]     row_slab [NUM_BANKS];

    assign role_adr[0]  = win.row1_adr;
    assign role_adr[1]  = win.row2_adr;
    assign role_adr[2]  = win.row3_adr;
    assign role_idx[0]  = win.row1_idx;
    assign role_idx[1]  = win.row2_idx;
    assign role_idx[2]  = win.row3_idx;
    assign bank_word[0] = bank1_data;
    assign bank_word[1] = bank2_data;
    assign bank_word[2] = bank3_data;
    assign bank_slab[0] = slab1;
    assign bank_slab[1] = slab2;
    assign bank_slab[2] = slab3;

    ////////////////////
    // Role to bank where row1 wins a tie
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_adr[b] = '0;
            bank_use[b] = 1'b0;
            for (int r = NUM_BANKS - 1; r >= 0; r--) begin
                if (role_idx[r] == BANK_IDX_W'(b + 1)) begin
                    bank_adr[b] = role_adr[r];
                    bank_use[b] = win.win_valid;
                end
            end
        end
    end

    // Indexes follow the read by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            row_valid <= 1'b0;
            for (int i = 0; i < NUM_BANKS; i++) begin
                idx_q[i]     <= '0;
                slab_wr_q[i] <= 1'b0;
            end
        end else if (advance) begin
            row_valid <= win.win_valid;
            for (int i = 0; i < NUM_BANKS; i++) begin
                idx_q[i]     <= role_idx[i];
                slab_wr_q[i] <= bank_use[i];
            end
        end
    end

    ////////////////////
    // Bank to role
    always_comb begin
        for (int r = 0; r < NUM_BANKS; r++) begin
            row_word[r] = '0;
            row_slab[r] = '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (idx_q[r] == BANK_IDX_W'(b + 1)) begin
                    row_word[r] = bank_word[b];
                    row_slab[r] = bank_slab[b];
                end
            end
        end
    end

    assign bank1_adr = bank_adr[0];
    assign bank2_adr = bank_adr[1];
    assign bank3_adr = bank_adr[2];
    assign slab1_wr  = slab_wr_q[0];
    assign slab2_wr  = slab_wr_q[1];
    assign slab3_wr  = slab_wr_q[2];
    assign row1_word = row_word[0];
    assign row2_word = row_word[1];
    assign row3_word = row_word[2];
    assign row1_slab = row_slab[0];
    assign row2_slab = row_slab[1];
    assign row3_slab = row_slab[2];

    // At most one role per bank
    assert property (@(posedge clk) disable iff (reset)
        !((win.row1_idx != '0 && win.row1_idx == win.row2_idx) ||
          (win.row2_idx != '0 && win.row2_idx == win.row3_idx) ||
          (win.row1_idx != '0 && win.row1_idx == win.row3_idx)));

endmodule

// File: source/line_bank_set.sv
module line_bank_set (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            advance,
    input  logic                            wr_en,
    input  logic [conv_pkg::BANK_IDX_W-1:0] wr_idx,
    input  logic [conv_pkg::ADR_W-1:0]      wr_adr,
    input  logic [conv_pkg::WORD_W-1:0]     wr_data,
    input  logic [conv_pkg::ADR_W-1:0]      bank1_adr,
    input  logic [conv_pkg::ADR_W-1:0]      bank2_adr,
    input  logic [conv_pkg::ADR_W-1:0]      bank3_adr,
    input  logic                            slab1_wr,
    input  logic                            slab2_wr,
    input  logic                            slab3_wr,
    output logic [conv_pkg::WORD_W-1:0]     bank1_data,
    output logic [conv_pkg::WORD_W-1:0]     bank2_data,
    output logic [conv_pkg::WORD_W-1:0]     bank3_data,
    output logic [conv_pkg::SLAB_W-1:0]     slab1,
    output logic [conv_pkg::SLAB_W-1:0]     slab2,
    output logic [conv_pkg::SLAB_W-1:0]     slab3
);
    import conv_pkg::*;

    row_word_u         mem [NUM_BANKS][WORDS_PER_ROW];
    row_word_u         rd_q [NUM_BANKS];
    logic [ADR_W-1:0]  rd_adr [NUM_BANKS];
    logic [ADR_W-1:0]  rd_adr_q [NUM_BANKS];
    logic              slab_wr [NUM_BANKS];
    logic [SLAB_W-1:0] slab_q [NUM_BANKS];

    assign rd_adr[0]  = bank1_adr;
    assign rd_adr[1]  = bank2_adr;
    assign rd_adr[2]  = bank3_adr;
    assign slab_wr[0] = slab1_wr;
    assign slab_wr[1] = slab2_wr;
    assign slab_wr[2] = slab3_wr;

    ////////////////////
    // Arrays, read data and slabs
    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (wr_en && (wr_idx == BANK_IDX_W'(b + 1))) begin
                mem[b][wr_adr] <= wr_data;
            end
            if (advance) begin
                rd_q[b] <= mem[b][rd_adr[b]];
            end
            // Slab takes the top pixels once the word has been consumed
            if (advance && slab_wr[b]) begin
                slab_q[b] <= rd_q[b].part.slab;
            end
        end
    end

    // Address of the word now on the read port
    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (reset) begin
                rd_adr_q[b] <= '0;
            end else if (advance) begin
                rd_adr_q[b] <= rd_adr[b];
            end
        end
    end

    assign bank1_data = rd_q[0];
    assign bank2_data = rd_q[1];
    assign bank3_data = rd_q[2];

    // Nothing to the left of word 0
    assign slab1 = (rd_adr_q[0] == '0) ? '0 : slab_q[0];
    assign slab2 = (rd_adr_q[1] == '0) ? '0 : slab_q[1];
    assign slab3 = (rd_adr_q[2] == '0) ? '0 : slab_q[2];

endmodule

// File: source/row_sequencer.sv
module row_sequencer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            advance,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [conv_pkg::WORD_W-1:0]     in_data,
    window_if.seq                           win,
    output logic                            wr_en,
    output logic [conv_pkg::BANK_IDX_W-1:0] wr_idx,
    output logic [conv_pkg::ADR_W-1:0]      wr_adr,
    output logic [conv_pkg::WORD_W-1:0]     wr_data
);
    import conv_pkg::*;

    logic                  accept;
    logic                  last_word;
    logic [ADR_W-1:0]      word_cnt;
    logic [BANK_IDX_W-1:0] cur_bank;
    logic [1:0]            rows_done;
    logic                  pend_valid;
    logic [ADR_W-1:0]      pend_adr;
    logic [BANK_IDX_W-1:0] pend_bank;

    // Bank that held the row before this one
    function automatic logic [BANK_IDX_W-1:0] prev_bank(input logic [BANK_IDX_W-1:0] b);
        return (b == BANK_IDX_W'(1)) ? BANK_IDX_W'(NUM_BANKS) : b - 1'b1;
    endfunction

    assign in_ready  = advance;
    assign accept    = in_valid && advance;
    assign last_word = (word_cnt == ADR_W'(WORDS_PER_ROW - 1));

    assign wr_en   = accept;
    assign wr_idx  = cur_bank;
    assign wr_adr  = word_cnt;
    assign wr_data = in_data;

    ////////////////////
    // Word, row and bank counters
    always_ff @(posedge clk) begin
        if (reset) begin
            word_cnt  <= '0;
            cur_bank  <= BANK_IDX_W'(1);
            rows_done <= '0;
        end else if (accept) begin
            word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            if (last_word) begin
                cur_bank <= (cur_bank == BANK_IDX_W'(NUM_BANKS)) ? BANK_IDX_W'(1)
                                                                 : cur_bank + 1'b1;
                // Saturates once two full rows are stored
                if (rows_done != 2'd2) begin
                    rows_done <= rows_done + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Window request one cycle behind the write
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid    <= 1'b0;
            win.win_valid <= 1'b0;
            win.row1_idx  <= '0;
            win.row2_idx  <= '0;
            win.row3_idx  <= '0;
        end else if (advance) begin
            pend_valid    <= accept && (rows_done == 2'd2);
            win.win_valid <= pend_valid;
            win.row3_idx  <= pend_valid ? pend_bank : '0;
            win.row2_idx  <= pend_valid ? prev_bank(pend_bank) : '0;
            win.row1_idx  <= pend_valid ? prev_bank(prev_bank(pend_bank)) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pend_adr       <= word_cnt;
            pend_bank      <= cur_bank;
            win.row1_adr   <= pend_adr;
            win.row2_adr   <= pend_adr;
            win.row3_adr   <= pend_adr;
            win.first_word <= (pend_adr == '0);
        end
    end

    // A window names three different banks
    assert property (@(posedge clk) disable iff (reset)
        win.win_valid |-> (win.row1_idx != '0) && (win.row2_idx != '0) &&
                          (win.row3_idx != '0) && (win.row1_idx != win.row2_idx) &&
                          (win.row2_idx != win.row3_idx) && (win.row1_idx != win.row3_idx));

endmodule

// File: source/window_if.sv
interface window_if;
    import conv_pkg::*;

    // Word address per row role with the oldest row first
    logic [ADR_W-1:0]      row1_adr;
    logic [ADR_W-1:0]      row2_adr;
    logic [ADR_W-1:0]      row3_adr;

    // Bank index per row role where 0 means none
    logic [BANK_IDX_W-1:0] row1_idx;
    logic [BANK_IDX_W-1:0] row2_idx;
    logic [BANK_IDX_W-1:0] row3_idx;

    logic                  win_valid;
    logic                  first_word;

    modport seq (
        output row1_adr, row2_adr, row3_adr,
        output row1_idx, row2_idx, row3_idx,
        output win_valid, first_word
    );

    modport router (
        input row1_adr, row2_adr, row3_adr,
        input row1_idx, row2_idx, row3_idx,
        input win_valid, first_word
    );

endinterface

// File: source/conv_pkg.sv
package conv_pkg;

    ////////////////////
    // Pixel and word geometry
    localparam int PIXEL_W       = 8;
    localparam int ROW_PIXELS    = 8;
    localparam int WORD_W        = PIXEL_W * ROW_PIXELS;
    localparam int WORDS_PER_ROW = 4;

    ////////////////////
    // Line banks
    localparam int ADR_W      = 2;
    localparam int BANK_IDX_W = 2;
    localparam int NUM_BANKS  = 3;
    localparam int SLAB_W     = 2 * PIXEL_W;

    ////////////////////
    // Filter output
    localparam int SUM_W = 12;
    localparam int OUT_W = SUM_W * ROW_PIXELS;

    // Pixel 0 sits in the low byte, pixels 6 and 7 form the slab half
    typedef union packed {
        logic [ROW_PIXELS-1:0][PIXEL_W-1:0] pix;
        struct packed {
            logic [SLAB_W-1:0]        slab;
            logic [WORD_W-SLAB_W-1:0] body;
        } part;
    } row_word_u;

endpackage
